//--- bench/dcache_tests.svh
`ifndef DCACHE_TESTS_SVH
`define DCACHE_TESTS_SVH

task automatic reset_quiet();
    repeat (20) begin
        @(posedge clk);
        if (addr_ok || data_ok || rd_req || wr_req) begin
            report_failure("cache outputs active after reset while valid is low");
        end
    end
endtask

task automatic read_miss_then_hit();
    dcache_pkg::word_t rd;
    int                lat;
    int                rd_before;
    rd_before = rd_count;
    run_access("read_miss", dcache_pkg::op_read, 32'h0000_1104, '0, '0, rd, lat);
    check_int("read_miss rd_req count", rd_before + 1, rd_count);
    check_addr("read_miss rd_addr", 32'h0000_1100, last_rd_addr);
    check_word("read_miss", expected_word(32'h0000_1104), rd);
    run_access("read_hit", dcache_pkg::op_read, 32'h0000_110c, '0, '0, rd, lat);
    check_int("read_hit latency", 1, lat);
    check_int("read_hit rd_req count", rd_before + 1, rd_count);
    check_word("read_hit", expected_word(32'h0000_110c), rd);
endtask

task automatic write_hit_merge();
    dcache_pkg::word_t rd;
    int                lat;
    run_access("write_hit", dcache_pkg::op_write, 32'h0000_1108, 4'b0110, 32'hdead_beef, rd, lat);
    apply_store(32'h0000_1108, 4'b0110, 32'hdead_beef);
    check_int("write_hit latency", 1, lat);
    run_access("read_merged", dcache_pkg::op_read, 32'h0000_1108, '0, '0, rd, lat);
    check_word("read_merged", expected_word(32'h0000_1108), rd);
endtask

// same index, three tags, two ways
task automatic dirty_eviction();
    dcache_pkg::word_t rd;
    int                lat;
    int                wr_before;
    run_access("evict_read_a", dcache_pkg::op_read, 32'h0000_2204, '0, '0, rd, lat);
    check_word("evict_read_a", expected_word(32'h0000_2204), rd);
    run_access("evict_write_a", dcache_pkg::op_write, 32'h0000_2204, 4'b1111, 32'h1234_5678,
               rd, lat);
    apply_store(32'h0000_2204, 4'b1111, 32'h1234_5678);
    run_access("evict_read_b", dcache_pkg::op_read, 32'h0000_3200, '0, '0, rd, lat);
    check_word("evict_read_b", expected_word(32'h0000_3200), rd);
    wr_before = wr_count;
    run_access("evict_read_c", dcache_pkg::op_read, 32'h0000_4208, '0, '0, rd, lat);
    check_word("evict_read_c", expected_word(32'h0000_4208), rd);
    check_int("evict wr_req count", wr_before + 1, wr_count);
    check_addr("evict wr_addr", 32'h0000_2200, last_wr_addr);
    check_line("evict wr_data", expected_line(32'h0000_2200), last_wr_line);
    run_access("evict_reread_a", dcache_pkg::op_read, 32'h0000_2204, '0, '0, rd, lat);
    check_word("evict_reread_a", expected_word(32'h0000_2204), rd);
endtask

task automatic back_to_back_reads();
    @(negedge clk);
    drive_req(dcache_pkg::op_read, 32'h0000_1100, '0, '0);
    wait_accept("b2b_first");
    @(negedge clk);
    drive_req(dcache_pkg::op_read, 32'h0000_110c, '0, '0);
    @(posedge clk);
    if (!data_ok) begin
        report_failure("b2b_first: no data_ok one cycle after accept");
    end
    check_word("b2b_first", expected_word(32'h0000_1100), rdata);
    if (!addr_ok) begin
        report_failure("b2b_second: not accepted in the cycle after the first");
    end
    @(negedge clk);
    valid = 1'b0;
    @(posedge clk);
    if (!data_ok) begin
        report_failure("b2b_second: no data_ok one cycle after accept");
    end
    check_word("b2b_second", expected_word(32'h0000_110c), rdata);
endtask

task automatic write_miss_allocate();
    dcache_pkg::word_t rd;
    int                lat;
    int                rd_before;
    rd_before = rd_count;
    run_access("write_miss", dcache_pkg::op_write, 32'h0000_5308, 4'b1001, 32'ha5c3_3c5a,
               rd, lat);
    apply_store(32'h0000_5308, 4'b1001, 32'ha5c3_3c5a);
    check_int("write_miss rd_req count", rd_before + 1, rd_count);
    check_addr("write_miss rd_addr", 32'h0000_5300, last_rd_addr);
    run_access("read_alloc", dcache_pkg::op_read, 32'h0000_5308, '0, '0, rd, lat);
    check_int("read_alloc latency", 1, lat);
    check_word("read_alloc", expected_word(32'h0000_5308), rd);
endtask

`endif

//--- bench/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

    localparam int INDEX_WIDTH = 8;
    localparam int TAG_WIDTH   = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - dcache_pkg::OFFSET_WIDTH;
    localparam int WORD_BITS   = dcache_pkg::WORD_WIDTH;
    localparam int CLK_PERIOD  = 40;
    localparam int TEST_COUNT  = 6;
    localparam int TEST_CYCLES = 400;
    localparam int WAIT_LIMIT  = 100;

    typedef logic [dcache_pkg::ADDR_WIDTH-1:0] addr_t;

    logic                                clk;
    logic                                resetn;
    logic                                valid;
    dcache_pkg::op_t                     op;
    logic [TAG_WIDTH-1:0]                tag;
    logic [INDEX_WIDTH-1:0]              index;
    logic [dcache_pkg::OFFSET_WIDTH-1:0] offset;
    dcache_pkg::wstrb_t                  wstrb;
    dcache_pkg::word_t                   wdata;
    logic                                addr_ok;
    logic                                data_ok;
    dcache_pkg::word_t                   rdata;
    logic                                rd_req;
    addr_t                               rd_addr;
    logic                                rd_rdy;
    logic                                ret_valid;
    logic                                ret_last;
    dcache_pkg::word_t                   ret_data;
    logic                                wr_req;
    addr_t                               wr_addr;
    dcache_pkg::line_t                   wr_data;
    logic                                wr_rdy;

    // backing memory, and the value every address should read
    dcache_pkg::word_t mem [addr_t];
    dcache_pkg::word_t shadow [addr_t];
    int                rd_count;
    int                wr_count;
    addr_t             last_rd_addr;
    addr_t             last_wr_addr;
    dcache_pkg::line_t last_wr_line;
    int                mismatch_count;
    int                failure_count;

    dcache_top #(.INDEX_WIDTH(INDEX_WIDTH)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic dcache_pkg::word_t fill_pattern(addr_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
    endfunction

    function automatic dcache_pkg::word_t mem_word(addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return fill_pattern(addr);
    endfunction

    function automatic dcache_pkg::word_t expected_word(addr_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return fill_pattern(addr);
    endfunction

    function automatic dcache_pkg::line_t expected_line(addr_t base);
        dcache_pkg::line_t line;
        for (int i = 0; i < dcache_pkg::LINE_WORDS; i++) begin
            line[i * WORD_BITS +: WORD_BITS] = expected_word(base + 4 * i);
        end
        return line;
    endfunction

    // enabled bytes replace the old ones
    function automatic void apply_store(addr_t addr, dcache_pkg::wstrb_t strb,
                                        dcache_pkg::word_t data);
        dcache_pkg::word_t w;
        w = expected_word(addr);
        for (int b = 0; b < WORD_BITS / 8; b++) begin
            if (strb[b]) begin
                w[b * 8 +: 8] = data[b * 8 +: 8];
            end
        end
        shadow[addr] = w;
    endfunction

    task automatic check_word(string name, dcache_pkg::word_t exp, dcache_pkg::word_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_line(string name, dcache_pkg::line_t exp, dcache_pkg::line_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_int(string name, int exp, int act);
        if (act != exp) begin
            mismatch_count++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report_failure(string msg);
        failure_count++;
        $display("error: %s", msg);
    endtask

    task automatic drive_req(dcache_pkg::op_t req_op, addr_t addr, dcache_pkg::wstrb_t strb,
                             dcache_pkg::word_t data);
        valid  = 1'b1;
        op     = req_op;
        tag    = addr[dcache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
        index  = addr[dcache_pkg::OFFSET_WIDTH +: INDEX_WIDTH];
        offset = addr[dcache_pkg::OFFSET_WIDTH-1:0];
        wstrb  = strb;
        wdata  = data;
    endtask

    task automatic wait_accept(string name);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!addr_ok && n < WAIT_LIMIT);
        if (!addr_ok) begin
            report_failure($sformatf("%s: request not accepted in %0d cycles", name, n));
        end
    endtask

    task automatic wait_data(string name, output dcache_pkg::word_t data, output int lat);
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!data_ok && lat < WAIT_LIMIT);
        data = rdata;
        if (!data_ok) begin
            report_failure($sformatf("%s: no data_ok within %0d cycles", name, lat));
        end
    endtask

    // one request from drive to result
    task automatic run_access(string name, dcache_pkg::op_t req_op, addr_t addr,
                              dcache_pkg::wstrb_t strb, dcache_pkg::word_t data,
                              output dcache_pkg::word_t result, output int lat);
        @(negedge clk);
        drive_req(req_op, addr, strb, data);
        wait_accept(name);
        @(negedge clk);
        valid = 1'b0;
        wait_data(name, result, lat);
    endtask

    // memory model with random ready delays and gaps between beats
    initial begin
        addr_t base;
        void'($urandom(2909));
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        rd_count  = 0;
        wr_count  = 0;
        forever begin
            @(negedge clk);
            if (wr_req) begin
                repeat ($urandom_range(3)) @(negedge clk);
                wr_rdy       = 1'b1;
                last_wr_addr = wr_addr;
                last_wr_line = wr_data;
                wr_count++;
                for (int i = 0; i < dcache_pkg::LINE_WORDS; i++) begin
                    mem[wr_addr + 4 * i] = wr_data[i * WORD_BITS +: WORD_BITS];
                end
                @(negedge clk);
                wr_rdy = 1'b0;
            end else if (rd_req) begin
                repeat ($urandom_range(3)) @(negedge clk);
                rd_rdy       = 1'b1;
                base         = rd_addr;
                last_rd_addr = rd_addr;
                rd_count++;
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int beat = 0; beat < dcache_pkg::LINE_WORDS; beat++) begin
                    repeat ($urandom_range(2)) @(negedge clk);
                    ret_valid = 1'b1;
                    ret_last  = (beat == dcache_pkg::LINE_WORDS - 1);
                    ret_data  = mem_word(base + 4 * beat);
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    initial begin
        #(TEST_COUNT * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles",
                 TEST_COUNT * TEST_CYCLES);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        $display("test failed");
        $finish;
    end

    `include "dcache_tests.svh"

    initial begin
        mismatch_count = 0;
        failure_count  = 0;
        resetn = 1'b0;
        valid  = 1'b0;
        op     = dcache_pkg::op_read;
        tag    = '0;
        index  = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        reset_quiet();
        read_miss_then_hit();
        write_hit_merge();
        dirty_eviction();
        back_to_back_reads();
        write_miss_allocate();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count + failure_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+bench
source/dcache_pkg.sv
source/dcache_tag_array.sv
source/dcache_data_array.sv
source/dcache_refill_buffer.sv
source/dcache_ctrl.sv
source/dcache_top.sv
bench/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module dcache_tb -f files.f -o dcache_sim

./obj_dir/dcache_sim | tee "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

//--- source/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl #(
    parameter int INDEX_WIDTH = 8,
    localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - dcache_pkg::OFFSET_WIDTH
) (
    input  logic                                clk,
    input  logic                                resetn,
    // pipe side
    input  logic                                valid,
    input  dcache_pkg::op_t                     op,
    input  logic [TAG_WIDTH-1:0]                tag,
    input  logic [INDEX_WIDTH-1:0]              index,
    input  logic [dcache_pkg::OFFSET_WIDTH-1:0] offset,
    input  dcache_pkg::wstrb_t                  wstrb,
    input  dcache_pkg::word_t                   wdata,
    output logic                                addr_ok,
    output logic                                data_ok,
    output dcache_pkg::word_t                   rdata,
    // arrays
    input  logic                                hit,
    input  logic                                hit_way,
    input  logic [TAG_WIDTH-1:0]                victim_tag,
    input  logic                                victim_dirty,
    input  dcache_pkg::line_t                   hit_line,
    input  dcache_pkg::line_t                   victim_line,
    input  dcache_pkg::line_t                   fill_line,
    input  logic                                fill_done,
    output logic                                rd_en,
    output logic [INDEX_WIDTH-1:0]              rd_index,
    output logic [TAG_WIDTH-1:0]                lookup_tag,
    output logic                                victim_way,
    output logic                                wr_en,
    output logic                                wr_way,
    output logic [INDEX_WIDTH-1:0]              wr_index,
    output logic [TAG_WIDTH-1:0]                wr_tag,
    output logic                                wr_dirty,
    output dcache_pkg::line_t                   wr_line,
    output logic [dcache_pkg::OFFSET_WIDTH-3:0] wr_word,
    output dcache_pkg::wstrb_t                  wr_wstrb,
    output dcache_pkg::word_t                   wr_wdata,
    output logic                                wr_merge,
    // memory side
    input  logic                                rd_rdy,
    input  logic                                wr_rdy,
    output logic                                rd_req,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]   rd_addr,
    output logic                                wr_req,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]   wr_addr,
    output dcache_pkg::line_t                   wr_data
);

    dcache_pkg::state_t state;

    // accepted request
    dcache_pkg::op_t                     req_op;
    logic [TAG_WIDTH-1:0]                req_tag;
    logic [INDEX_WIDTH-1:0]              req_index;
    logic [dcache_pkg::OFFSET_WIDTH-1:0] req_offset;
    dcache_pkg::wstrb_t                  req_wstrb;
    dcache_pkg::word_t                   req_wdata;

    logic              lookup_hit;
    logic              write_hit;
    logic              fill_write;
    dcache_pkg::line_t src_line;

    assign lookup_hit = (state == dcache_pkg::st_lookup) && hit;
    assign write_hit  = lookup_hit && (req_op == dcache_pkg::op_write);
    assign fill_write = (state == dcache_pkg::st_refill) && fill_done;

    // read hit lets the next request in behind it
    assign addr_ok = valid && ((state == dcache_pkg::st_idle) ||
                               (lookup_hit && (req_op == dcache_pkg::op_read)));
    assign data_ok = lookup_hit || fill_write;

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_op     <= op;
            req_tag    <= tag;
            req_index  <= index;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= dcache_pkg::st_idle;
            victim_way <= 1'b0;
        end else begin
            case (state)
                dcache_pkg::st_idle: begin
                    if (addr_ok) begin
                        state <= dcache_pkg::st_lookup;
                    end
                end
                dcache_pkg::st_lookup: begin
                    if (!hit) begin
                        state <= dcache_pkg::st_miss;
                    end else if (!addr_ok) begin
                        state <= dcache_pkg::st_idle;
                    end
                end
                dcache_pkg::st_miss: begin
                    // clean victim skips the write-back
                    if (!victim_dirty || wr_rdy) begin
                        state <= dcache_pkg::st_replace;
                    end
                end
                dcache_pkg::st_replace: begin
                    if (rd_rdy) begin
                        state <= dcache_pkg::st_refill;
                    end
                end
                dcache_pkg::st_refill: begin
                    if (fill_done) begin
                        state      <= dcache_pkg::st_idle;
                        victim_way <= victim_way + 1'b1;
                    end
                end
                default: begin
                    state <= dcache_pkg::st_idle;
                end
            endcase
        end
    end

    // array lookup starts on accept
    assign rd_en      = addr_ok;
    assign rd_index   = index;
    assign lookup_tag = req_tag;

    assign src_line = (state == dcache_pkg::st_refill) ? fill_line : hit_line;
    assign rdata    = src_line[int'(req_offset[dcache_pkg::OFFSET_WIDTH-1:2]) *
                               dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH];

    // store hit and line fill share one write port
    assign wr_en    = write_hit || fill_write;
    assign wr_way   = write_hit ? hit_way : victim_way;
    assign wr_index = req_index;
    assign wr_tag   = req_tag;
    assign wr_dirty = (req_op == dcache_pkg::op_write);
    assign wr_line  = src_line;
    assign wr_word  = req_offset[dcache_pkg::OFFSET_WIDTH-1:2];
    assign wr_wstrb = req_wstrb;
    assign wr_wdata = req_wdata;
    assign wr_merge = (req_op == dcache_pkg::op_write);

    assign rd_req  = (state == dcache_pkg::st_replace);
    assign rd_addr = {req_tag, req_index, {dcache_pkg::OFFSET_WIDTH{1'b0}}};

    assign wr_req  = (state == dcache_pkg::st_miss) && victim_dirty;
    assign wr_addr = {victim_tag, req_index, {dcache_pkg::OFFSET_WIDTH{1'b0}}};
    assign wr_data = victim_line;

    // a request taken during the write-back would reload the victim
    a_wr_req_held: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else $error("ctrl: write-back dropped or changed before wr_rdy");

endmodule

//--- source/dcache_data_array.sv
`timescale 1ns/100ps

module dcache_data_array #(
    parameter int INDEX_WIDTH = 8
) (
    input  logic                                clk,
    input  logic                                rd_en,
    input  logic [INDEX_WIDTH-1:0]              rd_index,
    input  logic                                hit_way,
    input  logic                                victim_way,
    input  logic                                wr_en,
    input  logic                                wr_way,
    input  logic [INDEX_WIDTH-1:0]              wr_index,
    input  dcache_pkg::line_t                   wr_line,
    input  logic [dcache_pkg::OFFSET_WIDTH-3:0] wr_word,
    input  dcache_pkg::wstrb_t                  wr_wstrb,
    input  dcache_pkg::word_t                   wr_wdata,
    input  logic                                wr_merge,
    output dcache_pkg::line_t                   hit_line,
    output dcache_pkg::line_t                   victim_line
);

    localparam int SETS = 2 ** INDEX_WIDTH;

    dcache_pkg::line_t mem [dcache_pkg::WAY_NUM][SETS];
    dcache_pkg::line_t line_q [dcache_pkg::WAY_NUM];
    dcache_pkg::line_t merged_line;

    // store bytes land on top of the supplied line
    always_comb begin
        merged_line = wr_line;
        if (wr_merge) begin
            for (int b = 0; b < dcache_pkg::WORD_WIDTH / 8; b++) begin
                if (wr_wstrb[b]) begin
                    merged_line[int'(wr_word) * dcache_pkg::WORD_WIDTH + b * 8 +: 8] =
                        wr_wdata[b * 8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < dcache_pkg::WAY_NUM; w++) begin
                line_q[w] <= mem[w][rd_index];
            end
        end
        if (wr_en) begin
            mem[wr_way][wr_index] <= merged_line;
        end
    end

    assign hit_line    = line_q[hit_way];
    assign victim_line = line_q[victim_way];

endmodule

//--- source/dcache_pkg.sv
package dcache_pkg;

    // address split
    localparam int ADDR_WIDTH   = 32;
    localparam int WORD_WIDTH   = 32;
    localparam int LINE_WORDS   = 4;
    localparam int OFFSET_WIDTH = 4;

    localparam int WAY_NUM = 2;

    typedef logic [WORD_WIDTH-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [LINE_WORDS*WORD_WIDTH-1:0] line_t;

    typedef logic [WORD_WIDTH/8-1:0] wstrb_t;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } op_t;

    // main FSM
    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_lookup  = 3'd1,
        st_miss    = 3'd2,
        st_replace = 3'd3,
        st_refill  = 3'd4
    } state_t;

endpackage

//--- source/dcache_refill_buffer.sv
`timescale 1ns/100ps

module dcache_refill_buffer (
    input  logic              clk,
    input  logic              resetn,
    input  logic              ret_valid,
    input  logic              ret_last,
    input  dcache_pkg::word_t ret_data,
    output dcache_pkg::line_t fill_line,
    output logic              fill_done
);

    localparam int BEAT_WIDTH = $clog2(dcache_pkg::LINE_WORDS);

    logic [BEAT_WIDTH-1:0] beat_cnt;
    dcache_pkg::line_t     line_q;

    // current beat dropped into its slot
    always_comb begin
        fill_line = line_q;
        fill_line[int'(beat_cnt) * dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH] = ret_data;
    end

    assign fill_done = ret_valid & ret_last;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (fill_done) begin
            beat_cnt <= '0;
        end else if (ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            line_q <= '0;
        end else if (ret_valid) begin
            line_q <= fill_line;
        end
    end

    // memory returns exactly one line per read
    a_last_on_fourth: assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> (ret_last == (beat_cnt == BEAT_WIDTH'(dcache_pkg::LINE_WORDS - 1))))
        else $error("refill buffer: ret_last not on the last beat of the line");

endmodule

//--- source/dcache_tag_array.sv
`timescale 1ns/100ps

module dcache_tag_array #(
    parameter int INDEX_WIDTH = 8,
    localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - dcache_pkg::OFFSET_WIDTH
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   rd_en,
    input  logic [INDEX_WIDTH-1:0] rd_index,
    input  logic [TAG_WIDTH-1:0]   lookup_tag,
    input  logic                   victim_way,
    input  logic                   wr_en,
    input  logic                   wr_way,
    input  logic [INDEX_WIDTH-1:0] wr_index,
    input  logic [TAG_WIDTH-1:0]   wr_tag,
    input  logic                   wr_dirty,
    output logic                   hit,
    output logic                   hit_way,
    output logic [TAG_WIDTH-1:0]   victim_tag,
    output logic                   victim_dirty
);

    localparam int SETS = 2 ** INDEX_WIDTH;

    logic [TAG_WIDTH-1:0] tag_mem [dcache_pkg::WAY_NUM][SETS];
    logic [dcache_pkg::WAY_NUM-1:0][SETS-1:0] valid_bits;
    logic [dcache_pkg::WAY_NUM-1:0][SETS-1:0] dirty_bits;

    // registered read of both ways
    logic [TAG_WIDTH-1:0]            tag_q [dcache_pkg::WAY_NUM];
    logic [dcache_pkg::WAY_NUM-1:0] valid_q;
    logic [dcache_pkg::WAY_NUM-1:0] dirty_q;
    logic [dcache_pkg::WAY_NUM-1:0] hit_vec;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            valid_q    <= '0;
        end else begin
            if (rd_en) begin
                for (int w = 0; w < dcache_pkg::WAY_NUM; w++) begin
                    valid_q[w] <= valid_bits[w][rd_index];
                end
            end
            if (wr_en) begin
                valid_bits[wr_way][wr_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < dcache_pkg::WAY_NUM; w++) begin
                tag_q[w]   <= tag_mem[w][rd_index];
                dirty_q[w] <= dirty_bits[w][rd_index];
            end
        end
        if (wr_en) begin
            tag_mem[wr_way][wr_index]    <= wr_tag;
            dirty_bits[wr_way][wr_index] <= wr_dirty;
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::WAY_NUM; w++) begin
            hit_vec[w] = valid_q[w] && (tag_q[w] == lookup_tag);
        end
    end

    assign hit     = |hit_vec;
    assign hit_way = hit_vec[1];

    assign victim_tag   = tag_q[victim_way];
    assign victim_dirty = valid_q[victim_way] & dirty_q[victim_way];

    // a line is only ever allocated into one way
    a_single_hit: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(hit_vec))
        else $error("tag array: both ways hit on one lookup");

endmodule

//--- source/dcache_top.sv
`timescale 1ns/100ps

module dcache_top #(
    parameter int INDEX_WIDTH = 8,
    localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - dcache_pkg::OFFSET_WIDTH
) (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                valid,
    input  dcache_pkg::op_t                     op,
    input  logic [TAG_WIDTH-1:0]                tag,
    input  logic [INDEX_WIDTH-1:0]              index,
    input  logic [dcache_pkg::OFFSET_WIDTH-1:0] offset,
    input  dcache_pkg::wstrb_t                  wstrb,
    input  dcache_pkg::word_t                   wdata,
    output logic                                addr_ok,
    output logic                                data_ok,
    output dcache_pkg::word_t                   rdata,
    output logic                                rd_req,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]   rd_addr,
    input  logic                                rd_rdy,
    input  logic                                ret_valid,
    input  logic                                ret_last,
    input  dcache_pkg::word_t                   ret_data,
    output logic                                wr_req,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]   wr_addr,
    output dcache_pkg::line_t                   wr_data,
    input  logic                                wr_rdy
);

    // lookup path
    logic                   rd_en;
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [TAG_WIDTH-1:0]   lookup_tag;
    logic                   hit;
    logic                   hit_way;
    logic                   victim_way;
    logic [TAG_WIDTH-1:0]   victim_tag;
    logic                   victim_dirty;
    dcache_pkg::line_t      hit_line;
    dcache_pkg::line_t      victim_line;

    // array write path
    logic                                wr_en;
    logic                                wr_way;
    logic [INDEX_WIDTH-1:0]              wr_index;
    logic [TAG_WIDTH-1:0]                wr_tag;
    logic                                wr_dirty;
    dcache_pkg::line_t                   wr_line;
    logic [dcache_pkg::OFFSET_WIDTH-3:0] wr_word;
    dcache_pkg::wstrb_t                  wr_wstrb;
    dcache_pkg::word_t                   wr_wdata;
    logic                                wr_merge;

    dcache_pkg::line_t fill_line;
    logic              fill_done;

    // port names line up across the blocks
    dcache_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) i_ctrl (.*);

    dcache_tag_array #(.INDEX_WIDTH(INDEX_WIDTH)) i_tag_array (.*);

    dcache_data_array #(.INDEX_WIDTH(INDEX_WIDTH)) i_data_array (.*);

    dcache_refill_buffer i_refill_buffer (.*);

endmodule
